// ==== project.f ====
src/cps_mmr_pkg.sv
src/cps_b_cfg.sv
src/cps_a_regs.sv
src/cps_b_regs.sv
src/cps_mmr.sv
sim/tb_cps_mmr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the CPS register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cps_mmr \
    -f project.f -o sim_cps_mmr

# the log decides the result, not the exit status of the run
./obj_dir/sim_cps_mmr 2>&1 | tee sim.log

grep -qx "All tests passed" sim.log

// ==== sim/mmr_tests.txt ====
# op x y z in hex; C shifts bytes x y z in (100 = empty), A/B write x with mode y and data z
# R reads x expecting z (y 1/2 = product halves), P players, V check, S strobe x
# reset values
V 1 0 1B00
V 1 1 0
V 1 4 0
V 1 5 3F
V 0 0 0
R 1F 0 FFFF
# CPS-A byte lanes with random data
A 06 10 0
V 0 0 0
A 06 11 0
V 0 0 0
A 06 12 0
V 0 0 0
A 06 13 0
V 0 0 0
A 0D 11 0
A 11 12 0
V 0 0 0
# copy strobes
A 05 00 8C40
V 0 0 0
S 0 0 0
A 00 02 0D00
S 1 0 0
# first map, prio2 disabled at 1f
C 7F FF 80
C 00 2C 78
C 56 34 12
C 30 36 34
C 2E 3E 2A
C 28 26 08
C 06 04 02
C 4A 32 100
R 19 0 040A
B 13 0 0A5C
R 13 0 0A5C
V 1 0 0A5C
B 14 0 1111
R 14 0 1111
B 17 0 4444
V 1 4 4444
B 1F 0 3333
R 1F 0 FFFF
V 1 3 0
B 18 0 FF15
R 18 0 0015
V 1 6 12
V 1 9 78
V 1 A 78
B 01 1 0
B 02 2 0
R 03 1 0
R 04 2 0
P 4B E5 3C
R 1A 0 A5A5
R 1B 0 7C7C
V 2 0 2C
V 2 1 8000
V 2 2 7FFF
R 0C 0 FFFF
# second map, in3 at zero and prio2 at 16
C 7F FF 80
C 00 2C 78
C 56 34 12
C 30 00 34
C 2E 2C 2A
C 28 26 08
C 06 04 02
C 4A 32 100
R 00 0 FFFF
B 16 0 5555
R 16 0 5555
V 1 3 5555

// ==== sim/tb_cps_mmr.sv ====
// Testbench for the CPS memory-mapped registers
// Replays the operations of sim/mmr_tests.txt on the bus, keeps a model
// of the CPS-A bank and checks reads, video outputs and copy strobes

`timescale 1ns/100ps

module tb_cps_mmr;

    logic                      clk;
    logic                      reg_rst;
    logic                      ppu_rstn;
    logic                      ppu1_cs;
    logic                      ppu2_cs;
    cps_mmr_pkg::reg_addr_t    addr;
    logic [1:0]                dsn;
    cps_mmr_pkg::reg_word_t    cpu_dout;
    logic                      cfg_we;
    logic [7:0]                cfg_data;
    cps_mmr_pkg::player_in_t   players;
    cps_mmr_pkg::reg_word_t    mmr_dout;
    cps_mmr_pkg::cps_a_video_t video_a;
    cps_mmr_pkg::cps_b_video_t video_b;
    logic                      pal_copy;
    logic                      obj_dma_ok;
    logic [5:0]                game;
    logic [15:0]               bank_offset;
    logic [15:0]               bank_mask;

    // expected CPS-A contents and the last multiplier operands
    cps_mmr_pkg::cps_a_video_t exp_a;
    cps_mmr_pkg::reg_word_t    op1;
    cps_mmr_pkg::reg_word_t    op2;
    logic [31:0]               lfsr;

    // configuration bytes as loaded, newest at byte 0
    logic [8*cps_mmr_pkg::cfg_bytes-1:0] cfg_model;

    string vb_names [0:10] = '{"layer_ctrl", "prio0", "prio1", "prio2", "prio3",
                               "pal_page_en", "layer_mask0", "layer_mask1",
                               "layer_mask2", "layer_mask3", "layer_mask4"};

    cps_mmr u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD000_0001;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit
    task automatic random_word(output cps_mmr_pkg::reg_word_t w);
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    // a low dsn bit means the lane takes the new byte
    function automatic cps_mmr_pkg::reg_word_t lanes_written(
        input cps_mmr_pkg::reg_word_t old_word,
        input cps_mmr_pkg::reg_word_t data,
        input logic [1:0]             lanes_n
    );
        cps_mmr_pkg::reg_word_t keep;
        keep = {{8{lanes_n[1]}}, {8{lanes_n[0]}}};
        return (old_word & keep) | (data & ~keep);
    endfunction

    task automatic model_a_write(input cps_mmr_pkg::reg_addr_t a, input logic [1:0] lanes_n,
                                 input cps_mmr_pkg::reg_word_t d);
        case (a)
            5'h00: exp_a.vram_obj_base = lanes_written(exp_a.vram_obj_base, d, lanes_n);
            5'h01: exp_a.vram1_base    = lanes_written(exp_a.vram1_base, d, lanes_n);
            5'h02: exp_a.vram2_base    = lanes_written(exp_a.vram2_base, d, lanes_n);
            5'h03: exp_a.vram3_base    = lanes_written(exp_a.vram3_base, d, lanes_n);
            5'h04: exp_a.vram_row_base = lanes_written(exp_a.vram_row_base, d, lanes_n);
            5'h05: exp_a.pal_base      = lanes_written(exp_a.pal_base, d, lanes_n);
            5'h06: exp_a.hpos1         = lanes_written(exp_a.hpos1, d, lanes_n);
            5'h07: exp_a.vpos1         = lanes_written(exp_a.vpos1, d, lanes_n);
            5'h08: exp_a.hpos2         = lanes_written(exp_a.hpos2, d, lanes_n);
            5'h09: exp_a.vpos2         = lanes_written(exp_a.vpos2, d, lanes_n);
            5'h0a: exp_a.hpos3         = lanes_written(exp_a.hpos3, d, lanes_n);
            5'h0b: exp_a.vpos3         = lanes_written(exp_a.vpos3, d, lanes_n);
            5'h0c: exp_a.hstar1        = lanes_written(exp_a.hstar1, d, lanes_n);
            5'h0d: exp_a.vstar1        = lanes_written(exp_a.vstar1, d, lanes_n);
            5'h0e: exp_a.hstar2        = lanes_written(exp_a.hstar2, d, lanes_n);
            5'h0f: exp_a.vstar2        = lanes_written(exp_a.vstar2, d, lanes_n);
            5'h10: exp_a.row_offset    = lanes_written(exp_a.row_offset, d, lanes_n);
            5'h11: exp_a.ppu_ctrl      = lanes_written(exp_a.ppu_ctrl, d, lanes_n);
            default: begin
                // nothing mapped
            end
        endcase
    endtask

    task automatic stop_with_failure(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input cps_mmr_pkg::reg_word_t got,
                              input cps_mmr_pkg::reg_word_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_with_failure("register value mismatch");
        end
    endtask

    task automatic check_video_a(input cps_mmr_pkg::cps_a_video_t got,
                                 input cps_mmr_pkg::cps_a_video_t exp);
        if (got !== exp) begin
            $display("** Error video_a: got %h, expected %h", got, exp);
            stop_with_failure("CPS-A video registers mismatch");
        end
    endtask

    task automatic check_video_b(input logic [31:0] field, input cps_mmr_pkg::cps_b_video_t got,
                                 input cps_mmr_pkg::reg_word_t exp);
        cps_mmr_pkg::reg_word_t val;
        case (field)
            0: val = got.layer_ctrl;
            1: val = got.prio0;
            2: val = got.prio1;
            3: val = got.prio2;
            4: val = got.prio3;
            5: val = {10'd0, got.pal_page_en};
            6: val = {8'd0, got.layer_mask0};
            7: val = {8'd0, got.layer_mask1};
            8: val = {8'd0, got.layer_mask2};
            9: val = {8'd0, got.layer_mask3};
            10: val = {8'd0, got.layer_mask4};
            default: stop_with_failure("unknown video_b field in the test file");
        endcase
        if (val !== exp) begin
            $display("** Error video_b.%s: got %h, expected %h", vb_names[field], val, exp);
            stop_with_failure("CPS-B video field mismatch");
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_with_failure("copy strobe mismatch");
        end
    endtask

    // starts and ends on a falling edge with the chip select high for one clock
    task automatic bus_cycle(input logic cs_a, input logic cs_b,
                             input cps_mmr_pkg::reg_addr_t a, input logic [1:0] lanes_n,
                             input cps_mmr_pkg::reg_word_t d);
        ppu1_cs  = cs_a;
        ppu2_cs  = cs_b;
        addr     = a;
        dsn      = lanes_n;
        cpu_dout = d;
        @(negedge clk);
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        dsn     = 2'b11;
    endtask

    // slot values above ff are empty
    task automatic load_cfg(input logic [8:0] b);
        if (!b[8]) begin
            cfg_we    = 1'b1;
            cfg_data  = b[7:0];
            cfg_model = {cfg_model[8*(cps_mmr_pkg::cfg_bytes-1)-1:0], b[7:0]};
            @(negedge clk);
            cfg_we = 1'b0;
        end
    endtask

    task automatic expect_strobe(input logic [31:0] which);
        string name;
        bit    seen;
        name = (which == 0) ? "pal_copy" : "obj_dma_ok";
        seen = 1'b0;
        for (int i = 0; i < 8 && !seen; i++) begin
            if (((which == 0) ? pal_copy : obj_dma_ok) === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!seen) begin
            stop_with_failure({"timeout waiting for a ", name, " pulse"});
        end
        @(negedge clk);
        check_strobe(name, (which == 0) ? pal_copy : obj_dma_ok, 1'b0);
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] x,
                          input logic [31:0] y, input logic [31:0] z);
        cps_mmr_pkg::reg_word_t d;
        logic [31:0]            prod;
        d = z[15:0];
        case (op)
            "C": begin
                load_cfg(x[8:0]);
                load_cfg(y[8:0]);
                load_cfg(z[8:0]);
            end
            "A": begin
                if (y[4]) begin
                    random_word(d);
                end
                model_a_write(x[4:0], y[1:0], d);
                bus_cycle(1'b1, 1'b0, x[4:0], y[1:0], d);
            end
            "B": begin
                if (y == 1) begin
                    random_word(d);
                    op1 = d;
                end else if (y == 2) begin
                    random_word(d);
                    op2 = d;
                end
                bus_cycle(1'b0, 1'b1, x[4:0], 2'b00, d);
            end
            "R": begin
                if (y != 0) begin
                    // product settles two idle cycles after the last operand
                    repeat (2) @(negedge clk);
                    prod = {16'd0, op1} * {16'd0, op2};
                    d = (y == 1) ? prod[15:0] : prod[31:16];
                end
                bus_cycle(1'b0, 1'b1, x[4:0], 2'b11, 16'h0000);
                check_word("mmr_dout", mmr_dout, d);
            end
            "P": players = {x[7:0], y[7:0], z[7:0]};
            "V": begin
                if (x == 0) begin
                    check_video_a(video_a, exp_a);
                end else if (x == 1) begin
                    check_video_b(y, video_b, d);
                end else if (y == 0) begin
                    check_word("game", {10'd0, game}, d);
                end else if (y == 1) begin
                    check_word("bank_offset", bank_offset, d);
                end else begin
                    check_word("bank_mask", bank_mask, d);
                end
            end
            "S": expect_strobe(x);
            default: stop_with_failure("unknown operation in the test file");
        endcase
    endtask

    initial begin
        int          fd;
        int          code;
        bit          done;
        logic [7:0]  op;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        string       line;
        reg_rst   = 1'b1;
        ppu_rstn  = 1'b1;
        ppu1_cs   = 1'b0;
        ppu2_cs   = 1'b0;
        addr      = '0;
        dsn       = 2'b11;
        cpu_dout  = '0;
        cfg_we    = 1'b0;
        cfg_data  = '0;
        players   = '0;
        exp_a     = '0;
        op1       = '0;
        op2       = '0;
        cfg_model = '0;
        lfsr      = 32'h6543_5904;
        repeat (4) @(negedge clk);
        reg_rst = 1'b0;

        check_word("mmr_dout", mmr_dout, 16'hFFFF);
        check_strobe("pal_copy", pal_copy, 1'b0);
        check_strobe("obj_dma_ok", obj_dma_ok, 1'b0);
        // middle priorities start at zero as well
        check_video_b(2, video_b, 16'h0000);
        check_video_b(3, video_b, 16'h0000);

        fd = $fopen("sim/mmr_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open sim/mmr_tests.txt");
        end
        done = 1'b0;
        for (int n = 0; n < 500 && !done; n++) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, " %h %h %h", x, y, z);
                if (code != 3) begin
                    stop_with_failure("malformed line in sim/mmr_tests.txt");
                end
                run_op(op, x, y, z);
            end
        end
        $fclose(fd);
        if (!done) begin
            stop_with_failure("test file did not end within the line limit");
        end

        // layer masks 1 and 2 of the last map sit in bytes 15 and 16
        check_video_b(7, video_b, {8'd0, cfg_model[8*15 +: 8]});
        check_video_b(8, video_b, {8'd0, cfg_model[8*16 +: 8]});

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== src/cps_a_regs.sv ====
// CPS-A register bank
// Fixed map of write-only video registers with byte-lane writes.
// Writes to the object base and palette base raise strobes for the
// object DMA and palette copy once the chip select is released

`timescale 1ns/100ps

module cps_a_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ppu1_cs,
    input  cps_mmr_pkg::reg_addr_t    addr,
    input  logic [1:0]                dsn,
    input  cps_mmr_pkg::reg_word_t    cpu_dout,
    output cps_mmr_pkg::cps_a_video_t video_a,
    output logic                      pal_copy,
    output logic                      obj_dma_ok
);

    // copy requests waiting for ppu1_cs to drop
    logic pend_copy;
    logic pend_dma;

    // replace only the byte lanes whose strobe is low
    function automatic cps_mmr_pkg::reg_word_t lane_merge(
        input cps_mmr_pkg::reg_word_t old_word,
        input cps_mmr_pkg::reg_word_t new_word,
        input logic [1:0]             lanes_n
    );
        cps_mmr_pkg::reg_word_t merged;
        merged[15:8] = lanes_n[1] ? old_word[15:8] : new_word[15:8];
        merged[7:0]  = lanes_n[0] ? old_word[7:0]  : new_word[7:0];
        return merged;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            video_a    <= '0;
            pend_copy  <= 1'b0;
            pend_dma   <= 1'b0;
            pal_copy   <= 1'b0;
            obj_dma_ok <= 1'b0;
        end else begin
            if (!ppu1_cs) begin
                // base registers are settled by now
                pal_copy   <= pend_copy;
                pend_copy  <= 1'b0;
                obj_dma_ok <= pend_dma;
                pend_dma   <= 1'b0;
            end else begin
                pal_copy <= 1'b0;
                case (addr)
                    5'h00: begin
                        video_a.vram_obj_base <=
                            lane_merge(video_a.vram_obj_base, cpu_dout, dsn);
                        pend_dma <= 1'b1;
                    end
                    5'h01: video_a.vram1_base <= lane_merge(video_a.vram1_base, cpu_dout, dsn);
                    5'h02: video_a.vram2_base <= lane_merge(video_a.vram2_base, cpu_dout, dsn);
                    5'h03: video_a.vram3_base <= lane_merge(video_a.vram3_base, cpu_dout, dsn);
                    5'h04: begin
                        video_a.vram_row_base <=
                            lane_merge(video_a.vram_row_base, cpu_dout, dsn);
                    end
                    5'h05: begin
                        video_a.pal_base <= lane_merge(video_a.pal_base, cpu_dout, dsn);
                        pend_copy        <= 1'b1;
                    end
                    // scroll positions
                    5'h06: video_a.hpos1  <= lane_merge(video_a.hpos1, cpu_dout, dsn);
                    5'h07: video_a.vpos1  <= lane_merge(video_a.vpos1, cpu_dout, dsn);
                    5'h08: video_a.hpos2  <= lane_merge(video_a.hpos2, cpu_dout, dsn);
                    5'h09: video_a.vpos2  <= lane_merge(video_a.vpos2, cpu_dout, dsn);
                    5'h0a: video_a.hpos3  <= lane_merge(video_a.hpos3, cpu_dout, dsn);
                    5'h0b: video_a.vpos3  <= lane_merge(video_a.vpos3, cpu_dout, dsn);
                    // star field
                    5'h0c: video_a.hstar1 <= lane_merge(video_a.hstar1, cpu_dout, dsn);
                    5'h0d: video_a.vstar1 <= lane_merge(video_a.vstar1, cpu_dout, dsn);
                    5'h0e: video_a.hstar2 <= lane_merge(video_a.hstar2, cpu_dout, dsn);
                    5'h0f: video_a.vstar2 <= lane_merge(video_a.vstar2, cpu_dout, dsn);
                    5'h10: begin
                        video_a.row_offset <= lane_merge(video_a.row_offset, cpu_dout, dsn);
                    end
                    5'h11: video_a.ppu_ctrl <= lane_merge(video_a.ppu_ctrl, cpu_dout, dsn);
                    default: begin
                        // unmapped words are ignored
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/cps_b_cfg.sv ====
// CPS-B configuration decoder
// A byte-wide shift register filled from the ROM download holds the
// per-game CPS-B layout; it is sliced here into register addresses,
// the chip ID, the layer masks and the ROM mapper fields

`timescale 1ns/100ps

module cps_b_cfg (
    input  logic                    clk,
    input  logic                    cfg_we,
    input  logic [7:0]              cfg_data,
    output cps_mmr_pkg::cps_b_map_t map
);

    logic [8*cps_mmr_pkg::cfg_bytes-1:0] cfg_sr;

    // raw byte at position idx of the shift register
    function automatic logic [7:0] cfg_byte(
        input logic [8*cps_mmr_pkg::cfg_bytes-1:0] sr,
        input int                                  idx
    );
        return sr[8*idx +: 8];
    endfunction

    // address bytes hold byte addresses, registers are word addressed
    function automatic cps_mmr_pkg::reg_addr_t cfg_addr(
        input logic [8*cps_mmr_pkg::cfg_bytes-1:0] sr,
        input int                                  idx
    );
        logic [7:0] b;
        b = sr[8*idx +: 8];
        return b[5:1];
    endfunction

    // newest byte enters at byte 0, older bytes move up
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            cfg_sr <= {cfg_sr[8*(cps_mmr_pkg::cfg_bytes-1)-1:0], cfg_data};
        end
    end

    always_comb begin
        map.addr_id       = cfg_addr(cfg_sr, 0);
        map.cpsb_id       = cfg_byte(cfg_sr, 1);
        map.addr_mult1    = cfg_addr(cfg_sr, 2);
        map.addr_mult2    = cfg_addr(cfg_sr, 3);
        map.addr_rslt0    = cfg_addr(cfg_sr, 4);
        map.addr_rslt1    = cfg_addr(cfg_sr, 5);
        map.addr_layer    = cfg_addr(cfg_sr, 6);
        map.addr_prio0    = cfg_addr(cfg_sr, 7);
        map.addr_prio1    = cfg_addr(cfg_sr, 8);
        map.addr_prio2    = cfg_addr(cfg_sr, 9);
        map.addr_prio3    = cfg_addr(cfg_sr, 10);
        map.addr_in2      = cfg_addr(cfg_sr, 11);
        map.addr_in3      = cfg_addr(cfg_sr, 12);
        map.addr_pal_page = cfg_addr(cfg_sr, 13);
        map.layer_mask0   = cfg_byte(cfg_sr, 14);
        map.layer_mask1   = cfg_byte(cfg_sr, 15);
        map.layer_mask2   = cfg_byte(cfg_sr, 16);
        map.layer_mask3   = cfg_byte(cfg_sr, 17);
        // mapper section, multi-byte values stored low byte first
        map.game          = cfg_sr[8*18 +: 6];
        map.bank_offset   = {cfg_byte(cfg_sr, 20), cfg_byte(cfg_sr, 19)};
        map.bank_mask     = {cfg_byte(cfg_sr, 22), cfg_byte(cfg_sr, 21)};
    end

endmodule

// ==== src/cps_b_regs.sv ====
// CPS-B register bank
// Register addresses come from the per-game map. Holds the layer control,
// priority masks, palette page enable and a 16x16 multiplier, and serves
// the ID and extra input ports through a registered read bus

`timescale 1ns/100ps

module cps_b_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ppu2_cs,
    input  cps_mmr_pkg::reg_addr_t    addr,
    input  logic [1:0]                dsn,
    input  cps_mmr_pkg::reg_word_t    cpu_dout,
    input  cps_mmr_pkg::cps_b_map_t   map,
    input  cps_mmr_pkg::player_in_t   players,
    output cps_mmr_pkg::cps_b_video_t video_b,
    output cps_mmr_pkg::reg_word_t    mmr_dout
);

    // address match per register
    logic hit_id;
    logic hit_mult1;
    logic hit_mult2;
    logic hit_rslt0;
    logic hit_rslt1;
    logic hit_layer;
    logic hit_prio0;
    logic hit_prio1;
    logic hit_prio2;
    logic hit_prio3;
    logic hit_pal_page;
    logic hit_in2;
    logic hit_in3;

    cps_mmr_pkg::reg_word_t layer_ctrl;
    cps_mmr_pkg::reg_word_t prio0;
    cps_mmr_pkg::reg_word_t prio1;
    cps_mmr_pkg::reg_word_t prio2;
    cps_mmr_pkg::reg_word_t prio3;
    logic [5:0]             pal_page_en;

    cps_mmr_pkg::reg_word_t mult1;
    cps_mmr_pkg::reg_word_t mult2;
    logic [31:0]            rslt;

    logic [7:0]             in2;
    logic [7:0]             in3;
    cps_mmr_pkg::reg_word_t rd_data;
    logic                   wr_en;

    // multiplier, priority and result slots at 0x1f do not exist in this game
    assign hit_id       = addr == map.addr_id;
    assign hit_mult1    = addr == map.addr_mult1 && map.addr_mult1 != 5'h1f;
    assign hit_mult2    = addr == map.addr_mult2 && map.addr_mult2 != 5'h1f;
    assign hit_rslt0    = addr == map.addr_rslt0 && map.addr_rslt0 != 5'h1f;
    assign hit_rslt1    = addr == map.addr_rslt1 && map.addr_rslt1 != 5'h1f;
    assign hit_layer    = addr == map.addr_layer;
    assign hit_prio0    = addr == map.addr_prio0 && map.addr_prio0 != 5'h1f;
    assign hit_prio1    = addr == map.addr_prio1 && map.addr_prio1 != 5'h1f;
    assign hit_prio2    = addr == map.addr_prio2 && map.addr_prio2 != 5'h1f;
    assign hit_prio3    = addr == map.addr_prio3 && map.addr_prio3 != 5'h1f;
    assign hit_pal_page = addr == map.addr_pal_page;
    // input ports at address zero are absent
    assign hit_in2      = addr == map.addr_in2 && map.addr_in2 != 5'h00;
    assign hit_in3      = addr == map.addr_in3 && map.addr_in3 != 5'h00;

    // only full word writes are taken
    assign wr_en = ppu2_cs && dsn == 2'b00;

    assign in2 = {players.start_button[2], players.coin_input[2], players.joystick3[5:0]};
    assign in3 = {players.start_button[3], players.coin_input[3], players.joystick4[5:0]};

    always_comb begin
        rd_data = 16'hFFFF;
        if (addr != 5'h1f) begin
            if (hit_id) begin
                rd_data = {4'd0, map.cpsb_id[7:4], 4'd0, map.cpsb_id[3:0]};
            end else if (hit_mult1) begin
                rd_data = mult1;
            end else if (hit_mult2) begin
                rd_data = mult2;
            end else if (hit_rslt0) begin
                rd_data = rslt[15:0];
            end else if (hit_rslt1) begin
                rd_data = rslt[31:16];
            end else if (hit_layer) begin
                rd_data = layer_ctrl;
            end else if (hit_prio0) begin
                rd_data = prio0;
            end else if (hit_prio1) begin
                rd_data = prio1;
            end else if (hit_prio2) begin
                rd_data = prio2;
            end else if (hit_prio3) begin
                rd_data = prio3;
            end else if (hit_pal_page) begin
                rd_data = {10'd0, pal_page_en};
            end else if (hit_in2) begin
                rd_data = {in2, in2};
            end else if (hit_in3) begin
                rd_data = {in3, in3};
            end
        end
    end

    // product lands one cycle after an operand changes
    always_ff @(posedge clk) begin
        if (wr_en && hit_mult1) begin
            mult1 <= cpu_dout;
        end
        if (wr_en && hit_mult2) begin
            mult2 <= cpu_dout;
        end
        rslt <= mult1 * mult2;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl  <= cps_mmr_pkg::layer_ctrl_rst;
            prio0       <= '0;
            prio1       <= '0;
            prio2       <= '0;
            prio3       <= '0;
            pal_page_en <= cps_mmr_pkg::pal_page_rst;
            mmr_dout    <= 16'hFFFF;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_data;
            if (wr_en && hit_layer)    layer_ctrl  <= cpu_dout;
            if (wr_en && hit_prio0)    prio0       <= cpu_dout;
            if (wr_en && hit_prio1)    prio1       <= cpu_dout;
            if (wr_en && hit_prio2)    prio2       <= cpu_dout;
            if (wr_en && hit_prio3)    prio3       <= cpu_dout;
            if (wr_en && hit_pal_page) pal_page_en <= cpu_dout[5:0];
        end
    end

    always_comb begin
        video_b.layer_ctrl  = layer_ctrl;
        video_b.prio0       = prio0;
        video_b.prio1       = prio1;
        video_b.prio2       = prio2;
        video_b.prio3       = prio3;
        video_b.pal_page_en = pal_page_en;
        video_b.layer_mask0 = map.layer_mask0;
        video_b.layer_mask1 = map.layer_mask1;
        video_b.layer_mask2 = map.layer_mask2;
        video_b.layer_mask3 = map.layer_mask3;
        // layer 4 has no mask byte of its own, reuses layer 3
        video_b.layer_mask4 = map.layer_mask3;
    end

endmodule

// ==== src/cps_mmr.sv ====
// CPS memory-mapped registers, top level
// Joins the CPS-B configuration decoder with the CPS-A and CPS-B
// register banks, which share the CPU bus

`timescale 1ns/100ps

module cps_mmr (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      ppu_rstn,
    input  logic                      ppu1_cs,
    input  logic                      ppu2_cs,
    input  cps_mmr_pkg::reg_addr_t    addr,
    input  logic [1:0]                dsn,
    input  cps_mmr_pkg::reg_word_t    cpu_dout,
    input  logic                      cfg_we,
    input  logic [7:0]                cfg_data,
    input  cps_mmr_pkg::player_in_t   players,
    output cps_mmr_pkg::reg_word_t    mmr_dout,
    output cps_mmr_pkg::cps_a_video_t video_a,
    output cps_mmr_pkg::cps_b_video_t video_b,
    output logic                      pal_copy,
    output logic                      obj_dma_ok,
    output logic [5:0]                game,
    output logic [15:0]               bank_offset,
    output logic [15:0]               bank_mask
);

    cps_mmr_pkg::cps_b_map_t map;
    logic                    bank_rst;

    // the video chips are also held in reset by the board
    assign bank_rst = reg_rst | ~ppu_rstn;

    cps_b_cfg u_cfg (
        .clk      (clk),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (map)
    );

    cps_a_regs u_cps_a (
        .clk        (clk),
        .rst        (bank_rst),
        .ppu1_cs    (ppu1_cs),
        .addr       (addr),
        .dsn        (dsn),
        .cpu_dout   (cpu_dout),
        .video_a    (video_a),
        .pal_copy   (pal_copy),
        .obj_dma_ok (obj_dma_ok)
    );

    cps_b_regs u_cps_b (
        .clk      (clk),
        .rst      (bank_rst),
        .ppu2_cs  (ppu2_cs),
        .addr     (addr),
        .dsn      (dsn),
        .cpu_dout (cpu_dout),
        .map      (map),
        .players  (players),
        .video_b  (video_b),
        .mmr_dout (mmr_dout)
    );

    // ROM mapper settings
    assign game        = map.game;
    assign bank_offset = map.bank_offset;
    assign bank_mask   = map.bank_mask;

endmodule

// ==== src/cps_mmr_pkg.sv ====
// CPS memory-mapped register package
// Register word types, the CPS-A and CPS-B output bundles, the decoded
// per-game CPS-B address map and the reset constants shared by both banks

package cps_mmr_pkg;

    // length of the CPS-B configuration shift register in bytes
    localparam int cfg_bytes = 23;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] reg_word_t;

    // CPS-A video registers, all write-only from the CPU
    typedef struct packed {
        reg_word_t hpos1;
        reg_word_t hpos2;
        reg_word_t hpos3;
        reg_word_t vpos1;
        reg_word_t vpos2;
        reg_word_t vpos3;
        reg_word_t hstar1;
        reg_word_t hstar2;
        reg_word_t vstar1;
        reg_word_t vstar2;
        reg_word_t vram1_base;
        reg_word_t vram2_base;
        reg_word_t vram3_base;
        reg_word_t vram_obj_base;
        reg_word_t vram_row_base;
        reg_word_t row_offset;
        reg_word_t pal_base;
        reg_word_t ppu_ctrl;
    } cps_a_video_t;

    // CPS-B map as decoded from the configuration bytes
    typedef struct packed {
        reg_addr_t   addr_id;
        reg_addr_t   addr_mult1;
        reg_addr_t   addr_mult2;
        reg_addr_t   addr_rslt0;
        reg_addr_t   addr_rslt1;
        reg_addr_t   addr_layer;
        reg_addr_t   addr_prio0;
        reg_addr_t   addr_prio1;
        reg_addr_t   addr_prio2;
        reg_addr_t   addr_prio3;
        reg_addr_t   addr_pal_page;
        reg_addr_t   addr_in2;
        reg_addr_t   addr_in3;
        logic [7:0]  cpsb_id;
        logic [7:0]  layer_mask0;
        logic [7:0]  layer_mask1;
        logic [7:0]  layer_mask2;
        logic [7:0]  layer_mask3;
        // mapper fields for the ROM banking
        logic [5:0]  game;
        logic [15:0] bank_offset;
        logic [15:0] bank_mask;
    } cps_b_map_t;

    // CPS-B outputs towards the video pipeline
    typedef struct packed {
        reg_word_t  layer_ctrl;
        reg_word_t  prio0;
        reg_word_t  prio1;
        reg_word_t  prio2;
        reg_word_t  prio3;
        logic [5:0] pal_page_en;
        logic [7:0] layer_mask0;
        logic [7:0] layer_mask1;
        logic [7:0] layer_mask2;
        logic [7:0] layer_mask3;
        logic [7:0] layer_mask4;
    } cps_b_video_t;

    // extra inputs read through the C board
    typedef struct packed {
        logic [3:0] start_button;
        logic [3:0] coin_input;
        logic [7:0] joystick3;
        logic [7:0] joystick4;
    } player_in_t;

    // default layer order after reset
    localparam reg_word_t  layer_ctrl_rst = 16'h1B00;
    // all six palette pages copied
    localparam logic [5:0] pal_page_rst   = 6'h3F;

endpackage
